// File: verilog.f
source/iso14443a_pkg.sv
source/pause_latch_and_synchroniser.sv
source/bit_cell_timer.sv
source/miller_decoder_fsm.sv
source/frame_assembler.sv
source/iso14443a_rx_top.sv
verification/tb_clock_gen.sv
verification/tb_iso14443a_rx.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the receive front end testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f \
    --top-module tb_iso14443a_rx \
    --Mdir obj_dir -o sim_tb

# the simulator exits non-zero on a fatal check, the log decides the result
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TB FAILED" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without failure"

// File: verification/tb_iso14443a_rx.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// runs with bit_ticks = 32 and 8 tick pauses; every strobe of the DUT must
// match the head of its queue, and all queues must drain by the end
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_iso14443a_rx;

    localparam int bit_ticks    = 32;
    localparam int reset_cycles = 16;
    localparam int pause_len    = 8;
    localparam int z_tick       = 0;
    localparam int x_tick       = bit_ticks / 2;
    localparam int no_pause     = -1;
    // the tests take quiet 1, full bytes 41, parity 14, short 12, illegal 5,
    // recovery 23 and short pause 5 cells, then 2 cells drain the last strobes
    localparam int total_cells    = 1 + 41 + 14 + 12 + 5 + 23 + 5 + 2;
    localparam int timeout_cycles = reset_cycles + total_cells * bit_ticks + 100;

    logic        clk;
    logic        pause_n_async;
    logic        afe_pause_n;
    logic [7:0]  rx_byte;
    logic        rx_byte_valid;
    logic        rx_parity_ok;
    logic        rx_done;
    logic [3:0]  rx_tail_bits;
    logic [7:0]  rx_tail_data;
    logic        rx_error;

    // expected bytes as {parity_ok, data}, expected ends as {tail_bits, tail_data}
    logic [8:0]  byte_q[$];
    logic [11:0] done_q[$];
    int          err_expected = 0;
    // bits of the frame that is about to be sent, in air order
    logic        tx_bits[$];
    logic [31:0] rng_state = 32'd13855;
    logic        pause_sent = 1'b0;
    string       test_name;
    int          cycle_count = 0;

    // queue heads, refreshed on the falling edge so they are stable at sampling
    logic        byte_known = 1'b0;
    logic [7:0]  exp_byte;
    logic        exp_par;
    logic        done_known = 1'b0;
    logic [3:0]  exp_tail_bits;
    logic [7:0]  exp_tail_data;
    logic        err_known = 1'b0;

    tb_clock_gen u_clock_gen (
        .clk (clk)
    );

    iso14443a_rx_top #(
        .bit_ticks (bit_ticks)
    ) u_iso14443a_rx_top (
        .clk           (clk),
        .pause_n_async (pause_n_async),
        .afe_pause_n   (afe_pause_n),
        .rx_byte       (rx_byte),
        .rx_byte_valid (rx_byte_valid),
        .rx_parity_ok  (rx_parity_ok),
        .rx_done       (rx_done),
        .rx_tail_bits  (rx_tail_bits),
        .rx_tail_data  (rx_tail_data),
        .rx_error      (rx_error)
    );

    task automatic report_failure();
        $display("TB FAILED");
        $fatal(1, "run stopped at the first failing check");
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // drives one bit cell whose pause begins at tick pause_at, or no pause if negative
    task automatic drive_cell(input int pause_at);
        int t;
        for (t = 0; t < bit_ticks; t++) begin
            @(posedge clk);
            afe_pause_n <= !(pause_at >= 0 && t >= pause_at && t < pause_at + pause_len);
            if (pause_at >= 0) begin
                pause_sent = 1'b1;
            end
        end
    endtask

    task automatic queue_bits(input logic [7:0] data, input int count);
        int i;
        for (i = 0; i < count; i++) begin
            tx_bits.push_back(data[i]);
        end
    endtask

    // odd parity makes the nine bits hold an odd number of ones
    task automatic queue_byte(input logic [7:0] data, input logic flip_parity);
        queue_bits(data, 8);
        tx_bits.push_back(~(^data) ^ flip_parity);
    endtask

    // in Modified Miller a one is X, and a zero is Y after a one and Z otherwise
    task automatic send_frame();
        logic last_one;
        logic b;
        last_one = 1'b0;
        drive_cell(z_tick);
        while (tx_bits.size() > 0) begin
            b = tx_bits.pop_front();
            if (b) begin
                drive_cell(x_tick);
            end else if (last_one) begin
                drive_cell(no_pause);
            end else begin
                drive_cell(z_tick);
            end
            last_one = b;
        end
        // end of communication is a logic zero followed by Y
        drive_cell(last_one ? no_pause : z_tick);
        drive_cell(no_pause);
        // two quiet cells let the decoder return to idle
        drive_cell(no_pause);
        drive_cell(no_pause);
    endtask

    task automatic queue_random_bytes(input int count);
        int i;
        for (i = 0; i < count; i++) begin
            rng_state = xorshift32(rng_state);
            queue_byte(rng_state[7:0], 1'b0);
            byte_q.push_back({1'b1, rng_state[7:0]});
        end
    endtask

    // a strobe consumes its queue entry in the same edge where it is checked
    always @(posedge clk) begin
        if (rx_byte_valid && byte_q.size() > 0) begin
            void'(byte_q.pop_front());
        end
        if (rx_done && done_q.size() > 0) begin
            void'(done_q.pop_front());
        end
        if (rx_error && err_expected > 0) begin
            err_expected = err_expected - 1;
        end
    end

    always @(negedge clk) begin
        byte_known = (byte_q.size() > 0);
        if (byte_known) begin
            {exp_par, exp_byte} = byte_q[0];
        end
        done_known = (done_q.size() > 0);
        if (done_known) begin
            {exp_tail_bits, exp_tail_data} = done_q[0];
        end
        err_known = (err_expected > 0);
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == timeout_cycles) begin
            $display("timeout in test %s after %0d cycles", test_name, cycle_count);
            report_failure();
        end
    end

    a_quiet_before_pause: assert property (@(posedge clk) disable iff (!pause_n_async)
        !pause_sent |-> !(rx_byte_valid || rx_done || rx_error))
        else begin
            $display("strobe seen in test %s before any pause was sent", test_name);
            report_failure();
        end

    a_byte_expected: assert property (@(posedge clk) disable iff (!pause_n_async)
        rx_byte_valid |-> byte_known)
        else begin
            $display("byte strobe in test %s while no byte was expected", test_name);
            report_failure();
        end

    a_byte_value: assert property (@(posedge clk) disable iff (!pause_n_async)
        rx_byte_valid && byte_known |-> rx_byte == exp_byte)
        else begin
            $display("[ERROR] %s rx_byte expected %h actual %h",
                     test_name, exp_byte, $sampled(rx_byte));
            report_failure();
        end

    a_byte_parity: assert property (@(posedge clk) disable iff (!pause_n_async)
        rx_byte_valid && byte_known |-> rx_parity_ok == exp_par)
        else begin
            $display("[ERROR] %s rx_parity_ok expected %b actual %b",
                     test_name, exp_par, $sampled(rx_parity_ok));
            report_failure();
        end

    a_done_expected: assert property (@(posedge clk) disable iff (!pause_n_async)
        rx_done |-> done_known)
        else begin
            $display("frame end in test %s while no frame end was expected", test_name);
            report_failure();
        end

    a_tail_bits: assert property (@(posedge clk) disable iff (!pause_n_async)
        rx_done && done_known |-> rx_tail_bits == exp_tail_bits)
        else begin
            $display("[ERROR] %s rx_tail_bits expected %0d actual %0d",
                     test_name, exp_tail_bits, $sampled(rx_tail_bits));
            report_failure();
        end

    a_tail_data: assert property (@(posedge clk) disable iff (!pause_n_async)
        rx_done && done_known |-> rx_tail_data == exp_tail_data)
        else begin
            $display("[ERROR] %s rx_tail_data expected %h actual %h",
                     test_name, exp_tail_data, $sampled(rx_tail_data));
            report_failure();
        end

    a_error_expected: assert property (@(posedge clk) disable iff (!pause_n_async)
        rx_error |-> err_known)
        else begin
            $display("rx_error in test %s while no error was expected", test_name);
            report_failure();
        end

    initial begin
        int wait_cycles;
        pause_n_async = 1'b0;
        afe_pause_n   = 1'b1;
        test_name     = "reset";
        repeat (reset_cycles) @(posedge clk);
        pause_n_async <= 1'b1;
        drive_cell(no_pause);

        test_name = "full_bytes";
        queue_random_bytes(4);
        done_q.push_back({4'd0, 8'h00});
        send_frame();

        // the data byte is still delivered and only the parity flag drops
        test_name = "wrong_parity";
        rng_state = xorshift32(rng_state);
        queue_byte(rng_state[7:0], 1'b1);
        byte_q.push_back({1'b0, rng_state[7:0]});
        done_q.push_back({4'd0, 8'h00});
        send_frame();

        test_name = "short_frame";
        queue_bits(8'h26, 7);
        done_q.push_back({4'd7, 8'h26});
        send_frame();

        // start, a logic one, then Z, which no legal frame contains
        test_name = "illegal_sequence";
        err_expected = err_expected + 1;
        drive_cell(z_tick);
        drive_cell(x_tick);
        drive_cell(z_tick);
        drive_cell(no_pause);
        drive_cell(no_pause);

        test_name = "recovery";
        queue_random_bytes(2);
        done_q.push_back({4'd0, 8'h00});
        send_frame();

        // a 1 ns pause between two edges is followed by silence after the start cell
        test_name = "short_pause";
        err_expected = err_expected + 1;
        @(posedge clk);
        #1;
        afe_pause_n <= 1'b0;
        #1;
        afe_pause_n <= 1'b1;
        repeat (4) drive_cell(no_pause);

        wait_cycles = 0;
        while ((byte_q.size() > 0 || done_q.size() > 0 || err_expected > 0)
               && wait_cycles < 2 * bit_ticks) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (byte_q.size() == 0 && done_q.size() == 0 && err_expected == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("expected strobes never arrived: %0d bytes, %0d ends, %0d errors",
                     byte_q.size(), done_q.size(), err_expected);
            report_failure();
        end
    end

endmodule

// File: verification/tb_clock_gen.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// free running testbench clock, 4 ns period, starts low at time zero
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int half_period_ns = 2
) (
    output logic clk
);

    initial clk = 1'b0;

    // the clock never stops, not even while a pause is on the field
    always #(half_period_ns) clk = ~clk;

endmodule

// File: source/iso14443a_rx_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// receive front end only, without CRC_A, anticollision or load modulation
// the clock must keep running while afe_pause_n is low
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module iso14443a_rx_top #(
    parameter int bit_ticks = iso14443a_pkg::default_bit_ticks
) (
    input  logic       clk,
    input  logic       pause_n_async,
    input  logic       afe_pause_n,
    output logic [7:0] rx_byte,
    output logic       rx_byte_valid,
    output logic       rx_parity_ok,
    output logic       rx_done,
    output logic [3:0] rx_tail_bits,
    output logic [7:0] rx_tail_data,
    output logic       rx_error
);

    import iso14443a_pkg::*;

    logic           pause_n_sync;
    logic           pause_start;
    logic           symbol_valid;
    miller_symbol_t symbol;
    // cell_run is high whenever the decoder's decode_state_t is not st_idle
    logic           cell_start;
    logic           cell_run;
    logic           bit_valid;
    logic           bit_value;
    logic           frame_start;
    logic           frame_end;
    logic           frame_abort;

    pause_latch_and_synchroniser u_pause (
        .clk           (clk),
        .pause_n_async (pause_n_async),
        .afe_pause_n   (afe_pause_n),
        .pause_n_sync  (pause_n_sync)
    );

    bit_cell_timer #(
        .bit_ticks (bit_ticks)
    ) u_timer (
        .clk           (clk),
        .pause_n_async (pause_n_async),
        .pause_n_sync  (pause_n_sync),
        .cell_start    (cell_start),
        .cell_run      (cell_run),
        .pause_start   (pause_start),
        .symbol_valid  (symbol_valid),
        .symbol        (symbol)
    );

    miller_decoder_fsm u_decoder (
        .clk           (clk),
        .pause_n_async (pause_n_async),
        .pause_start   (pause_start),
        .symbol_valid  (symbol_valid),
        .symbol        (symbol),
        .cell_start    (cell_start),
        .cell_run      (cell_run),
        .bit_valid     (bit_valid),
        .bit_value     (bit_value),
        .frame_start   (frame_start),
        .frame_end     (frame_end),
        .frame_abort   (frame_abort)
    );

    frame_assembler u_assembler (
        .clk           (clk),
        .pause_n_async (pause_n_async),
        .bit_valid     (bit_valid),
        .bit_value     (bit_value),
        .frame_start   (frame_start),
        .frame_end     (frame_end),
        .frame_abort   (frame_abort),
        .rx_byte       (rx_byte),
        .rx_byte_valid (rx_byte_valid),
        .rx_parity_ok  (rx_parity_ok),
        .rx_done       (rx_done),
        .rx_tail_bits  (rx_tail_bits),
        .rx_tail_data  (rx_tail_data),
        .rx_error      (rx_error)
    );

endmodule

// File: source/frame_assembler.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bytes arrive LSB first with odd parity after each; no CRC_A check here
// all outputs are one-cycle strobes with no back-pressure
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module frame_assembler (
    input  logic       clk,
    input  logic       pause_n_async,
    input  logic       bit_valid,
    input  logic       bit_value,
    input  logic       frame_start,
    input  logic       frame_end,
    input  logic       frame_abort,
    output logic [7:0] rx_byte,
    output logic       rx_byte_valid,
    output logic       rx_parity_ok,
    output logic       rx_done,
    output logic [3:0] rx_tail_bits,
    output logic [7:0] rx_tail_data,
    output logic       rx_error
);

    // bits collected so far in the current group of nine
    logic [3:0] bit_count;
    // data bits land at their own index, so a short tail stays right aligned
    logic [7:0] group_data;
    // running xor of the data bits in the group
    logic       group_par;

    always_ff @(posedge clk, negedge pause_n_async) begin
        if (!pause_n_async) begin
            bit_count     <= '0;
            rx_byte_valid <= 1'b0;
            rx_done       <= 1'b0;
            rx_error      <= 1'b0;
        end else begin
            rx_byte_valid <= 1'b0;
            rx_done       <= 1'b0;
            rx_error      <= 1'b0;
            if (frame_abort) begin
                rx_error  <= 1'b1;
                bit_count <= '0;
            end else if (frame_end) begin
                rx_done   <= 1'b1;
                bit_count <= '0;
            end else if (frame_start) begin
                bit_count <= '0;
            end else if (bit_valid) begin
                // the ninth bit is the parity bit and closes the group
                if (bit_count == 4'd8) begin
                    rx_byte_valid <= 1'b1;
                    bit_count     <= '0;
                end else begin
                    bit_count <= bit_count + 1'b1;
                end
            end
        end
    end

    // group contents and the reported values travel with the strobes above
    always_ff @(posedge clk) begin
        if (frame_start || frame_end || frame_abort) begin
            group_data <= '0;
            group_par  <= 1'b0;
        end else if (bit_valid && (bit_count == 4'd8)) begin
            group_data <= '0;
            group_par  <= 1'b0;
        end else if (bit_valid) begin
            group_data[bit_count[2:0]] <= bit_value;
            group_par                  <= group_par ^ bit_value;
        end
        if (bit_valid && (bit_count == 4'd8)) begin
            rx_byte      <= group_data;
            // odd parity means nine bits with an odd number of ones
            rx_parity_ok <= group_par ^ bit_value;
        end
        if (frame_end) begin
            rx_tail_bits <= bit_count;
            rx_tail_data <= group_data;
        end
    end

    // at most eight bits wait in the group before the ninth empties it
    a_group_of_nine: assert property (
        @(posedge clk) disable iff (!pause_n_async)
        bit_count <= 4'd8
    );

endmodule

// File: source/miller_decoder_fsm.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one decoded bit is always held back, so the zero of the end of
// communication pattern never reaches the frame assembler
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module miller_decoder_fsm (
    input  logic                         clk,
    input  logic                         pause_n_async,
    input  logic                         pause_start,
    input  logic                         symbol_valid,
    input  iso14443a_pkg::miller_symbol_t symbol,
    output logic                         cell_start,
    output logic                         cell_run,
    output logic                         bit_valid,
    output logic                         bit_value,
    output logic                         frame_start,
    output logic                         frame_end,
    output logic                         frame_abort
);

    import iso14443a_pkg::*;

    decode_state_t state;
    decode_state_t state_next;
    // the cell in progress is the start of communication itself
    logic          soc_cell;
    logic          soc_next;
    logic          emit;
    logic          emit_value;
    logic          end_now;
    logic          abort_now;

    // the first pause of a frame opens the cell grid
    assign cell_start = pause_start && (state == st_idle);
    assign cell_run   = (state != st_idle);

    always_comb begin
        state_next = state;
        soc_next   = soc_cell;
        emit       = 1'b0;
        // whatever is emitted is the bit held in the state
        emit_value = (state == st_last_one);
        end_now    = 1'b0;
        abort_now  = 1'b0;
        if (cell_start) begin
            state_next = st_first;
            soc_next   = 1'b1;
        end else if (symbol_valid) begin
            if (soc_cell) begin
                // the opening cell only has to be a clean Z
                soc_next  = 1'b0;
                abort_now = (symbol != sym_z);
            end else begin
                case (symbol)
                    sym_x: begin
                        emit       = (state != st_first);
                        state_next = st_last_one;
                    end
                    sym_z: begin
                        // Z never follows a logic one in a legal frame
                        if (state == st_last_one) begin
                            abort_now = 1'b1;
                        end else begin
                            emit       = (state == st_last_zero);
                            state_next = st_last_zero;
                        end
                    end
                    sym_y: begin
                        if (state == st_last_one) begin
                            emit       = 1'b1;
                            state_next = st_last_zero;
                        end else if (state == st_last_zero) begin
                            // zero then Y is the end of communication
                            end_now = 1'b1;
                        end else begin
                            abort_now = 1'b1;
                        end
                    end
                    default: begin
                        abort_now = 1'b1;
                    end
                endcase
            end
            if (abort_now || end_now) begin
                state_next = st_idle;
                soc_next   = 1'b0;
            end
        end
    end

    always_ff @(posedge clk, negedge pause_n_async) begin
        if (!pause_n_async) begin
            state       <= st_idle;
            soc_cell    <= 1'b0;
            bit_valid   <= 1'b0;
            frame_start <= 1'b0;
            frame_end   <= 1'b0;
            frame_abort <= 1'b0;
        end else begin
            state       <= state_next;
            soc_cell    <= soc_next;
            bit_valid   <= emit;
            frame_start <= cell_start;
            frame_end   <= end_now;
            frame_abort <= abort_now;
        end
    end

    // the bit value only means something while bit_valid is high
    always_ff @(posedge clk) begin
        bit_value <= emit_value;
    end

    // each symbol gives at most one of a bit, a frame end or an abort
    a_one_event: assert property (
        @(posedge clk) disable iff (!pause_n_async)
        $onehot0({bit_valid, frame_end, frame_abort})
    );

endmodule

// File: source/bit_cell_timer.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bit_ticks must be even and at least 16; the grid is set by the first
// pause of a frame, so every later pause carries the same sync delay
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module bit_cell_timer #(
    parameter int bit_ticks = iso14443a_pkg::default_bit_ticks
) (
    input  logic                         clk,
    input  logic                         pause_n_async,
    input  logic                         pause_n_sync,
    input  logic                         cell_start,
    input  logic                         cell_run,
    output logic                         pause_start,
    output logic                         symbol_valid,
    output iso14443a_pkg::miller_symbol_t symbol
);

    import iso14443a_pkg::*;

    localparam int cnt_w = $clog2(bit_ticks);
    localparam logic [cnt_w-1:0] last_tick    = cnt_w'(bit_ticks - 1);
    localparam logic [cnt_w-1:0] quarter_tick = cnt_w'(bit_ticks / 4);
    localparam logic [cnt_w-1:0] late_tick    = cnt_w'((3 * bit_ticks) / 4);

    logic             pause_n_prev;
    logic [cnt_w-1:0] cell_count;
    // a pause has already been seen in the current cell
    logic             pause_seen;
    // a second pause turned up in the current cell
    logic             pause_twice;
    miller_symbol_t   first_class;
    miller_symbol_t   pause_class;
    logic             cell_active;
    logic             cell_last;

    // the counter also runs in the cell_start cycle, before cell_run rises
    assign cell_active  = cell_run | cell_start;
    assign cell_last    = (cell_count == last_tick);
    assign symbol_valid = cell_last;

    // pause_start marks the falling edge of the synchronised pause one cycle late
    always_ff @(posedge clk, negedge pause_n_async) begin
        if (!pause_n_async) begin
            pause_n_prev <= 1'b1;
            pause_start  <= 1'b0;
        end else begin
            pause_n_prev <= pause_n_sync;
            pause_start  <= pause_n_prev & ~pause_n_sync;
        end
    end

    // where the current pause would land if it were the only one
    always_comb begin
        if (cell_count < quarter_tick) begin
            pause_class = sym_z;
        end else if (cell_count < late_tick) begin
            pause_class = sym_x;
        end else begin
            pause_class = sym_err;
        end
    end

    // the last tick of a cell still counts, so a pause there is folded in
    always_comb begin
        if (pause_twice || (pause_seen && pause_start)) begin
            symbol = sym_err;
        end else if (pause_seen) begin
            symbol = first_class;
        end else if (pause_start) begin
            symbol = pause_class;
        end else begin
            symbol = sym_y;
        end
    end

    always_ff @(posedge clk, negedge pause_n_async) begin
        if (!pause_n_async) begin
            cell_count  <= '0;
            pause_seen  <= 1'b0;
            pause_twice <= 1'b0;
            first_class <= sym_y;
        end else if (!cell_active) begin
            cell_count  <= '0;
            pause_seen  <= 1'b0;
            pause_twice <= 1'b0;
        end else if (cell_last) begin
            cell_count  <= '0;
            pause_seen  <= 1'b0;
            pause_twice <= 1'b0;
        end else begin
            cell_count <= cell_count + 1'b1;
            if (pause_start && pause_seen) begin
                pause_twice <= 1'b1;
            end else if (pause_start) begin
                pause_seen  <= 1'b1;
                first_class <= pause_class;
            end
        end
    end

    // a cell only closes while the decoder still holds its frame open
    a_symbol_in_frame: assert property (
        @(posedge clk) disable iff (!pause_n_async)
        symbol_valid |-> cell_run
    );

endmodule

// File: source/pause_latch_and_synchroniser.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// the pause input may be shorter than a clock period; it is caught
// asynchronously and released a fixed three rising edges after it ends
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module pause_latch_and_synchroniser (
    input  logic clk,
    input  logic pause_n_async,
    input  logic afe_pause_n,
    output logic pause_n_sync
);

    // low as soon as a pause begins, back high on the first edge after it ends
    logic pause_n_caught;
    // first synchroniser stage, may go metastable
    logic pause_n_meta;

    // the pause itself is the asynchronous clear of this flop, so even a
    // pause that falls between two clock edges leaves it low until an edge
    // the D input is tied high and every edge after the pause reloads a one
    // reset wins over a pause so the subsystem comes up with no pause seen
    always_ff @(posedge clk, negedge pause_n_async, negedge afe_pause_n) begin
        if (!pause_n_async) begin
            pause_n_caught <= 1'b1;
        end else if (!afe_pause_n) begin
            pause_n_caught <= 1'b0;
        end else begin
            pause_n_caught <= 1'b1;
        end
    end

    // the caught level changes asynchronously on its falling side, so it
    // passes through two flops before the rest of the design sees it
    // there is no feedback to the catching flop, which keeps the release
    // delay at three edges whatever the pause length
    always_ff @(posedge clk, negedge pause_n_async) begin
        if (!pause_n_async) begin
            pause_n_meta <= 1'b1;
            pause_n_sync <= 1'b1;
        end else begin
            pause_n_meta <= pause_n_caught;
            pause_n_sync <= pause_n_meta;
        end
    end

endmodule

// File: source/iso14443a_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types for the Type A receive path; the timing default assumes a
// 13.56 MHz clock that keeps running through every pause
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package iso14443a_pkg;

    // classification of one bit cell by where its pause sits
    typedef enum logic [1:0] {
        // pause somewhere in the second half of the cell
        sym_x   = 2'b00,
        // no pause anywhere in the cell
        sym_y   = 2'b01,
        // pause right at the start of the cell
        sym_z   = 2'b10,
        // pause too late, or more than one pause in a cell
        sym_err = 2'b11
    } miller_symbol_t;

    // decoder states; the last two also hold the pending bit
    typedef enum logic [1:0] {
        // waiting for the pause that marks start of communication
        st_idle      = 2'b00,
        // start of communication seen, nothing decoded yet
        st_first     = 2'b01,
        // a logic one is pending
        st_last_one  = 2'b10,
        // a logic zero is pending, possibly the end of communication zero
        st_last_zero = 2'b11
    } decode_state_t;

    // one bit cell is 128 carrier periods, which gives 106 kbit/s
    localparam int default_bit_ticks = 128;

endpackage
